//--- all.f
common/lc3b_pkg.sv
datapath/regfile.sv
datapath/forwarding_unit.sv
datapath/cpu_datapath.sv
source/control_rom.sv
source/hazard_detection.sv
source/lc3b_cpu.sv
sim/tb_mem_model.sv
sim/tb_lc3b_cpu.sv

//--- common/lc3b_pkg.sv
package lc3b_pkg;

    typedef logic [15:0] lc3b_word;
    typedef logic [2:0] lc3b_reg;
    typedef logic [2:0] lc3b_nzp;

    // standard LC-3b encodings, only some are implemented
    typedef enum logic [3:0] {
        op_br   = 4'b0000,
        op_add  = 4'b0001,
        op_ldb  = 4'b0010,
        op_stb  = 4'b0011,
        op_jsr  = 4'b0100,
        op_and  = 4'b0101,
        op_ldr  = 4'b0110,
        op_str  = 4'b0111,
        op_rti  = 4'b1000,
        op_not  = 4'b1001,
        op_ldi  = 4'b1010,
        op_sti  = 4'b1011,
        op_jmp  = 4'b1100,
        op_shf  = 4'b1101,
        op_lea  = 4'b1110,
        op_trap = 4'b1111
    } lc3b_opcode;

    typedef enum logic [1:0] {
        alu_add,
        alu_and,
        alu_not,
        alu_pass
    } lc3b_aluop;

    // second alu operand select
    localparam logic [1:0] alumux_reg  = 2'd0;
    localparam logic [1:0] alumux_imm5 = 2'd1;
    localparam logic [1:0] alumux_off6 = 2'd2;

    // all zero is a bubble, a BR with no condition bits
    typedef struct packed {
        lc3b_opcode opcode;
        lc3b_aluop  aluop;
        logic [1:0] alumux_sel;
        logic       offset6_lsse;
        logic       d_mem_read;
        logic       d_mem_write;
        logic       load_regfile;
        logic       load_cc;
        logic       regfilemux_sel;
        logic       src2_is_dest;
    } lc3b_control_word;

endpackage

//--- datapath/cpu_datapath.sv
module cpu_datapath import lc3b_pkg::*; #(
    parameter lc3b_word RESET_PC = 16'h0000
) (
    input  logic             i_arst_n,
    input  logic             clk,
    input  lc3b_control_word i_cw,
    input  logic             i_load,
    input  logic             i_bubble_ex,
    input  logic             i_flush,

    input  logic             i_i_mem_resp,
    input  lc3b_word         i_i_mem_rdata,
    output lc3b_word         o_i_mem_address,

    output lc3b_opcode       o_opcode,
    output logic             o_ir_5,
    output lc3b_reg          o_src1_id,
    output lc3b_reg          o_src2_id,
    output logic             o_src2_used_id,
    output logic             o_load_ex,
    output lc3b_reg          o_dest_ex,
    output logic             o_br_taken,
    output logic             o_d_access_mem,

    input  logic             i_d_mem_resp,
    input  lc3b_word         i_d_mem_rdata,
    output lc3b_word         o_d_mem_address,
    output lc3b_word         o_d_mem_wdata,
    output logic             o_d_mem_read,
    output logic             o_d_mem_write,
    output logic [1:0]       o_d_mem_byte_enable
);

    lc3b_word         pc, pc_plus2, ir_buf, ir_in;
    logic             adv_front;
    lc3b_word         ir_id, pc_id;
    lc3b_word         reg_a, reg_b;

    lc3b_control_word cw_ex;
    lc3b_word         ir_ex, pc_ex, a_ex, b_ex;
    lc3b_reg          src2_ex;
    logic [1:0]       fwd_a_sel, fwd_b_sel;
    lc3b_word         opa, opb, off6_adj, alu_b, alu_out;
    lc3b_word         br_target, result_ex, wdata_ex;

    lc3b_control_word cw_mem;
    lc3b_reg          dest_mem;
    lc3b_word         result_mem, wdata_mem, mdr_mem, rdata_mem;
    logic             d_done;

    lc3b_control_word cw_wb;
    lc3b_reg          dest_wb;
    lc3b_word         result_wb, mdr_wb, regfilemux_out;
    lc3b_nzp          cc, gencc;

    // fetch
    assign pc_plus2 = pc + 16'd2;
    assign o_i_mem_address = pc;
    // response may come while the rest of the pipe is stalled
    assign ir_in = i_i_mem_resp ? i_i_mem_rdata : ir_buf;
    assign adv_front = i_load && !i_bubble_ex && !i_flush;

    // decode
    assign o_opcode = lc3b_opcode'(ir_id[15:12]);
    assign o_ir_5 = ir_id[5];
    assign o_src1_id = ir_id[8:6];
    assign o_src2_id = i_cw.src2_is_dest ? ir_id[11:9] : ir_id[2:0];
    assign o_src2_used_id = i_cw.src2_is_dest ||
                            (i_cw.load_regfile && i_cw.alumux_sel == alumux_reg &&
                             i_cw.aluop != alu_not);

    regfile regfile_i (
        .clk      (clk),
        .i_arst_n (i_arst_n),
        .i_load   (cw_wb.load_regfile),
        .i_in     (regfilemux_out),
        .i_src_a  (o_src1_id),
        .i_src_b  (o_src2_id),
        .i_dest   (dest_wb),
        .o_reg_a  (reg_a),
        .o_reg_b  (reg_b)
    );

    // execute
    assign src2_ex = cw_ex.src2_is_dest ? ir_ex[11:9] : ir_ex[2:0];
    assign o_load_ex = cw_ex.d_mem_read;
    assign o_dest_ex = ir_ex[11:9];

    forwarding_unit forwarding_unit_i (
        .i_src1_ex         (ir_ex[8:6]),
        .i_src2_ex         (src2_ex),
        .i_dest_mem        (dest_mem),
        .i_dest_wb         (dest_wb),
        .i_load_regfile_mem(cw_mem.load_regfile),
        .i_load_regfile_wb (cw_wb.load_regfile),
        .o_forward_a_sel   (fwd_a_sel),
        .o_forward_b_sel   (fwd_b_sel)
    );

    always_comb begin
        case (fwd_a_sel)
            2'b01:   opa = result_mem;
            2'b10:   opa = regfilemux_out;
            default: opa = a_ex;
        endcase
        case (fwd_b_sel)
            2'b01:   opb = result_mem;
            2'b10:   opb = regfilemux_out;
            default: opb = b_ex;
        endcase
    end

    assign off6_adj = cw_ex.offset6_lsse ? {{9{ir_ex[5]}}, ir_ex[5:0], 1'b0}
                                         : {{10{ir_ex[5]}}, ir_ex[5:0]};

    always_comb begin
        case (cw_ex.alumux_sel)
            alumux_imm5: alu_b = {{11{ir_ex[4]}}, ir_ex[4:0]};
            alumux_off6: alu_b = off6_adj;
            default:     alu_b = opb;
        endcase
        case (cw_ex.aluop)
            alu_add: alu_out = opa + alu_b;
            alu_and: alu_out = opa & alu_b;
            alu_not: alu_out = ~opa;
            default: alu_out = alu_b;
        endcase
    end

    // branch target rides in the result slot down to writeback
    assign br_target = pc_ex + {{6{ir_ex[8]}}, ir_ex[8:0], 1'b0};
    assign result_ex = (cw_ex.opcode == op_br) ? br_target : alu_out;
    assign wdata_ex = (cw_ex.opcode == op_stb) ? {opb[7:0], opb[7:0]} : opb;

    // memory, a taken branch in writeback kills the access
    assign o_d_mem_read = cw_mem.d_mem_read && !d_done && !o_br_taken;
    assign o_d_mem_write = cw_mem.d_mem_write && !d_done && !o_br_taken;
    assign o_d_access_mem = o_d_mem_read || o_d_mem_write;
    assign o_d_mem_address = result_mem;
    assign o_d_mem_wdata = wdata_mem;
    assign o_d_mem_byte_enable = (cw_mem.opcode != op_stb) ? 2'b11 :
                                 (result_mem[0] ? 2'b10 : 2'b01);
    assign rdata_mem = i_d_mem_resp ? i_d_mem_rdata : mdr_mem;

    // writeback
    assign regfilemux_out = cw_wb.regfilemux_sel ? mdr_wb : result_wb;
    assign gencc = regfilemux_out[15] ? 3'b100 : ((regfilemux_out == '0) ? 3'b010 : 3'b001);
    // the BR nzp field sits where a destination would
    assign o_br_taken = (cw_wb.opcode == op_br) && ((dest_wb & cc) != '0);

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            pc <= RESET_PC;
            ir_id <= '0;
            cw_ex <= '0;
            ir_ex <= '0;
            cw_mem <= '0;
            dest_mem <= '0;
            cw_wb <= '0;
            dest_wb <= '0;
            d_done <= 1'b0;
            cc <= 3'b010;
        end else begin
            if (i_load && i_flush) begin
                pc <= result_wb;
                ir_id <= '0;
            end else if (adv_front) begin
                pc <= pc_plus2;
                ir_id <= ir_in;
            end
            if (i_load) begin
                if (i_flush || i_bubble_ex) begin
                    cw_ex <= '0;
                    ir_ex <= '0;
                end else begin
                    cw_ex <= i_cw;
                    ir_ex <= ir_id;
                end
                if (i_flush) begin
                    cw_mem <= '0;
                    dest_mem <= '0;
                    cw_wb <= '0;
                    dest_wb <= '0;
                end else begin
                    cw_mem <= cw_ex;
                    dest_mem <= ir_ex[11:9];
                    cw_wb <= cw_mem;
                    dest_wb <= dest_mem;
                end
            end
            // one response per access, cleared when a new one enters
            if (i_load) begin
                d_done <= 1'b0;
            end else if (i_d_mem_resp) begin
                d_done <= 1'b1;
            end
            if (cw_wb.load_cc) begin
                cc <= gencc;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_i_mem_resp) begin
            ir_buf <= i_i_mem_rdata;
        end
        if (i_d_mem_resp) begin
            mdr_mem <= i_d_mem_rdata;
        end
        if (adv_front) begin
            pc_id <= pc_plus2;
        end
        if (i_load) begin
            pc_ex <= pc_id;
            a_ex <= reg_a;
            b_ex <= reg_b;
            result_mem <= result_ex;
            wdata_mem <= wdata_ex;
            result_wb <= result_mem;
            mdr_wb <= rdata_mem;
        end
    end

    a_d_rw_exclusive: assert property (
        @(posedge clk) disable iff (!i_arst_n)
        !(o_d_mem_read && o_d_mem_write)
    );

    // address holds until the memory answers
    a_d_addr_stable: assert property (
        @(posedge clk) disable iff (!i_arst_n)
        (o_d_access_mem && !i_d_mem_resp) |=> $stable(o_d_mem_address)
    );

endmodule

//--- datapath/forwarding_unit.sv
module forwarding_unit import lc3b_pkg::*; (
    input  lc3b_reg    i_src1_ex,
    input  lc3b_reg    i_src2_ex,
    input  lc3b_reg    i_dest_mem,
    input  lc3b_reg    i_dest_wb,
    input  logic       i_load_regfile_mem,
    input  logic       i_load_regfile_wb,
    output logic [1:0] o_forward_a_sel,
    output logic [1:0] o_forward_b_sel
);

    // 00 register file, 01 memory stage, 10 writeback stage
    always_comb begin
        o_forward_a_sel = 2'b00;
        o_forward_b_sel = 2'b00;

        // younger result wins
        if (i_load_regfile_mem && i_dest_mem == i_src1_ex) begin
            o_forward_a_sel = 2'b01;
        end else if (i_load_regfile_wb && i_dest_wb == i_src1_ex) begin
            o_forward_a_sel = 2'b10;
        end

        if (i_load_regfile_mem && i_dest_mem == i_src2_ex) begin
            o_forward_b_sel = 2'b01;
        end else if (i_load_regfile_wb && i_dest_wb == i_src2_ex) begin
            o_forward_b_sel = 2'b10;
        end
    end

endmodule

//--- datapath/regfile.sv
module regfile import lc3b_pkg::*; (
    input  logic     clk,
    input  logic     i_arst_n,
    input  logic     i_load,
    input  lc3b_word i_in,
    input  lc3b_reg  i_src_a,
    input  lc3b_reg  i_src_b,
    input  lc3b_reg  i_dest,
    output lc3b_word o_reg_a,
    output lc3b_word o_reg_b
);

    lc3b_word regs [8];

    // falling edge write, decode reads the new value before the rising edge
    always_ff @(negedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            for (int i = 0; i < 8; i++) begin
                regs[i] <= '0;
            end
        end else if (i_load) begin
            regs[i_dest] <= i_in;
        end
    end

    assign o_reg_a = regs[i_src_a];
    assign o_reg_b = regs[i_src_b];

endmodule

//--- sim/tb_lc3b_cpu.sv
module tb_lc3b_cpu import lc3b_pkg::*; ();

    localparam lc3b_word RESET_PC = 16'h0000;
    localparam int MAX_CYCLES = 4000;

    logic       clk;
    logic       arst_n;
    logic       imem_resp;
    lc3b_word   imem_rdata;
    lc3b_word   imem_addr;
    logic       imem_read;
    logic       dmem_resp;
    lc3b_word   dmem_rdata;
    lc3b_word   dmem_addr;
    lc3b_word   dmem_wdata;
    logic       dmem_read;
    logic       dmem_write;
    logic [1:0] dmem_be;

    // store records from the reference model hold {byte enable, address, data}
    logic [33:0] store_q [$];
    lc3b_word    tgt_q [$];
    lc3b_word    ref_mem [lc3b_word];
    lc3b_word    halt_pc;
    logic        exp_valid;
    lc3b_word    exp_addr;
    lc3b_word    exp_data;
    logic [1:0]  exp_be;
    logic        fetched_once;
    logic        redirect_armed;
    lc3b_word    redirect_pc;

    lc3b_cpu #(
        .RESET_PC (RESET_PC)
    ) lc3b_cpu_i (
        .i_arst_n            (arst_n),
        .clk                 (clk),
        .i_i_mem_resp        (imem_resp),
        .i_i_mem_rdata       (imem_rdata),
        .o_i_mem_address     (imem_addr),
        .o_i_mem_read        (imem_read),
        .i_d_mem_resp        (dmem_resp),
        .i_d_mem_rdata       (dmem_rdata),
        .o_d_mem_address     (dmem_addr),
        .o_d_mem_wdata       (dmem_wdata),
        .o_d_mem_read        (dmem_read),
        .o_d_mem_write       (dmem_write),
        .o_d_mem_byte_enable (dmem_be)
    );

    tb_mem_model imem_i (
        .clk (clk), .i_arst_n (arst_n), .i_read (imem_read), .i_write (1'b0),
        .i_address (imem_addr), .i_wdata ('0), .i_byte_enable (2'b11),
        .o_resp (imem_resp), .o_rdata (imem_rdata)
    );

    tb_mem_model dmem_i (
        .clk (clk), .i_arst_n (arst_n), .i_read (dmem_read), .i_write (dmem_write),
        .i_address (dmem_addr), .i_wdata (dmem_wdata), .i_byte_enable (dmem_be),
        .o_resp (dmem_resp), .o_rdata (dmem_rdata)
    );

    always #20 clk = ~clk;

    task automatic report_mismatch(input string msg);
        $display("[ERROR] %0t: %s", $time, msg);
        $display("*** TEST FAILED ***");
        $fatal(1, "stopped at first mismatch");
    endtask

    task automatic report_timeout(input string msg);
        $display("Timeout: %s", msg);
        $display("*** TEST FAILED ***");
        $fatal(1, "stopped on timeout");
    endtask

    task automatic pop_expected_store;
        if (store_q.size() > 0) begin
            {exp_be, exp_addr, exp_data} = store_q.pop_front();
            exp_valid = 1'b1;
        end else begin
            exp_valid = 1'b0;
        end
    endtask

    task automatic load_program;
        // ALU ops in both forms placed back to back so operands forward
        imem_i.mem[0] = 16'h1225;
        imem_i.mem[1] = 16'h147D;
        imem_i.mem[2] = 16'h1642;
        imem_i.mem[3] = 16'h58E6;
        imem_i.mem[4] = 16'h5AC2;
        imem_i.mem[5] = 16'h9D3F;
        // word stores of R1, R3, R4, R5, R6 to 0x20 onwards
        imem_i.mem[6] = 16'h7210;
        imem_i.mem[7] = 16'h7611;
        imem_i.mem[8] = 16'h7812;
        imem_i.mem[9] = 16'h7A13;
        imem_i.mem[10] = 16'h7C14;
        // LDR R7 from 0x30 with ADD R7 and STR R7 right behind it
        imem_i.mem[11] = 16'h6E18;
        imem_i.mem[12] = 16'h1FC1;
        imem_i.mem[13] = 16'h7E15;
        // zero flag set so BRz skips a store and BRp falls through
        imem_i.mem[14] = 16'h54A0;
        imem_i.mem[15] = 16'h0401;
        imem_i.mem[16] = 16'h7216;
        imem_i.mem[17] = 16'h0201;
        imem_i.mem[18] = 16'h7617;
        // byte stores to an even and an odd address, then spin in place
        imem_i.mem[19] = 16'h3C08;
        imem_i.mem[20] = 16'h3648;
        imem_i.mem[21] = 16'h0FFF;
        for (int i = 22; i < 26; i++) begin
            imem_i.mem[i] = 16'h0000;
        end
        dmem_i.mem[16'h0018] = 16'h1234;
        ref_mem[16'h0030] = 16'h1234;
    endtask

    // in-order ISA model over the loaded program
    task automatic run_reference;
        lc3b_word regs [8];
        lc3b_nzp  cc;
        lc3b_word pc, ir, a, b, res, addr, tgt;
        logic     wr;
        logic     halted;
        int       steps;
        for (int i = 0; i < 8; i++) begin
            regs[i] = '0;
        end
        cc = 3'b010;
        pc = RESET_PC;
        halted = 1'b0;
        steps = 0;
        while (!halted && steps < 200) begin
            ir = imem_i.mem[pc[15:1]];
            a = regs[ir[8:6]];
            b = ir[5] ? {{11{ir[4]}}, ir[4:0]} : regs[ir[2:0]];
            wr = 1'b0;
            pc = pc + 16'd2;
            case (lc3b_opcode'(ir[15:12]))
                op_add: begin
                    res = a + b;
                    wr = 1'b1;
                end
                op_and: begin
                    res = a & b;
                    wr = 1'b1;
                end
                op_not: begin
                    res = ~a;
                    wr = 1'b1;
                end
                op_ldr: begin
                    addr = a + {{9{ir[5]}}, ir[5:0], 1'b0};
                    res = ref_mem.exists(addr) ? ref_mem[addr] : '0;
                    wr = 1'b1;
                end
                op_str: begin
                    addr = a + {{9{ir[5]}}, ir[5:0], 1'b0};
                    ref_mem[addr] = regs[ir[11:9]];
                    store_q.push_back({2'b11, addr, regs[ir[11:9]]});
                end
                op_stb: begin
                    addr = a + {{10{ir[5]}}, ir[5:0]};
                    b = {2{regs[ir[11:9]][7:0]}};
                    store_q.push_back({(addr[0] ? 2'b10 : 2'b01), addr, b});
                end
                op_br: begin
                    if ((ir[11:9] & cc) != 3'b000) begin
                        tgt = pc + {{6{ir[8]}}, ir[8:0], 1'b0};
                        tgt_q.push_back(tgt);
                        halted = (tgt == pc - 16'd2);
                        pc = tgt;
                    end
                end
                default: ;
            endcase
            if (wr) begin
                regs[ir[11:9]] = res;
                cc = res[15] ? 3'b100 : ((res == '0) ? 3'b010 : 3'b001);
            end
            steps++;
        end
        halt_pc = pc;
    endtask

    always @(posedge clk) begin
        if (arst_n) begin
            if (imem_resp) begin
                fetched_once <= 1'b1;
            end
            if (dmem_write && dmem_resp) begin
                pop_expected_store();
            end
            // the spin loop at the end keeps redirecting to itself
            redirect_armed <= lc3b_cpu_i.load && lc3b_cpu_i.flush;
            if (lc3b_cpu_i.load && lc3b_cpu_i.flush) begin
                if (tgt_q.size() > 0) begin
                    redirect_pc <= tgt_q.pop_front();
                end else begin
                    redirect_pc <= halt_pc;
                end
            end
        end
    end

    a_first_fetch_at_reset_pc: assert property (
        @(posedge clk) disable iff (!arst_n)
        (imem_read && !fetched_once) |-> (imem_addr == RESET_PC)
    ) else report_mismatch("first fetch address differs from the reset PC");

    a_no_data_before_fetch: assert property (
        @(posedge clk) disable iff (!arst_n)
        !fetched_once |-> !(dmem_read || dmem_write)
    ) else report_mismatch("data access before the first fetch response");

    a_store_matches_model: assert property (
        @(posedge clk) disable iff (!arst_n)
        (dmem_write && dmem_resp) |->
            (exp_valid && dmem_addr == exp_addr && dmem_wdata == exp_data && dmem_be == exp_be)
    ) else report_mismatch("store address, data or byte enable differs from the model");

    a_data_addr_held: assert property (
        @(posedge clk) disable iff (!arst_n)
        ((dmem_read || dmem_write) && !dmem_resp) |=>
            (!(dmem_read || dmem_write) || $stable(dmem_addr))
    ) else report_mismatch("data address moved while the access was pending");

    a_fetch_addr_held: assert property (
        @(posedge clk) disable iff (!arst_n)
        (imem_read && !imem_resp) |=> (!imem_read || $stable(imem_addr))
    ) else report_mismatch("fetch address moved while the read was pending");

    a_redirect_target: assert property (
        @(posedge clk) disable iff (!arst_n)
        redirect_armed |-> (imem_addr == redirect_pc)
    ) else report_mismatch("fetch address after a taken branch is not its target");

    initial begin
        int cycles;
        clk = 1'b0;
        arst_n = 1'b0;
        fetched_once = 1'b0;
        redirect_armed = 1'b0;
        redirect_pc = '0;
        exp_valid = 1'b0;
        @(negedge clk);
        load_program();
        run_reference();
        pop_expected_store();
        repeat (7) @(negedge clk);
        arst_n = 1'b1;
        cycles = 0;
        while ((exp_valid || store_q.size() > 0) && cycles < MAX_CYCLES) begin
            @(negedge clk);
            cycles++;
        end
        if (exp_valid || store_q.size() > 0) begin
            report_timeout("not all expected stores reached the data port");
        end else begin
            $display("*** TEST PASSED ***");
            $finish;
        end
    end

endmodule

//--- sim/tb_mem_model.sv
module tb_mem_model import lc3b_pkg::*; #(
    parameter logic [31:0] SEED = 32'h7f62_69c4
) (
    input  logic       clk,
    input  logic       i_arst_n,
    input  logic       i_read,
    input  logic       i_write,
    input  lc3b_word   i_address,
    input  lc3b_word   i_wdata,
    input  logic [1:0] i_byte_enable,
    output logic       o_resp,
    output lc3b_word   o_rdata
);

    lc3b_word mem [32768];
    integer   seed;
    logic     busy;
    int       wait_left;
    int       lat;

    initial begin
        seed = SEED;
        o_resp = 1'b0;
        o_rdata = '0;
        busy = 1'b0;
        wait_left = 0;
        // every word differs from every other word
        for (int i = 0; i < 32768; i++) begin
            mem[i] = lc3b_word'(i * 2) ^ 16'hc35a;
        end
    end

    // responses change on the falling edge, away from the sampling edge
    always @(negedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_resp <= 1'b0;
            busy <= 1'b0;
        end else if (o_resp || !(i_read || i_write)) begin
            // one cycle pulse, the next level is a new request
            o_resp <= 1'b0;
            busy <= 1'b0;
        end else begin
            if (busy) begin
                lat = wait_left;
            end else begin
                lat = $unsigned($random(seed)) % 4;
            end
            if (lat == 0) begin
                o_resp <= 1'b1;
                busy <= 1'b0;
                if (i_write) begin
                    if (i_byte_enable[0]) begin
                        mem[i_address[15:1]][7:0] <= i_wdata[7:0];
                    end
                    if (i_byte_enable[1]) begin
                        mem[i_address[15:1]][15:8] <= i_wdata[15:8];
                    end
                end else begin
                    o_rdata <= mem[i_address[15:1]];
                end
            end else begin
                busy <= 1'b1;
                wait_left <= lat - 1;
            end
        end
    end

endmodule

//--- source/control_rom.sv
module control_rom import lc3b_pkg::*; (
    input  lc3b_opcode       i_opcode,
    input  logic             i_ir_5,
    output lc3b_control_word o_cw
);

    always_comb begin
        o_cw = '0;
        o_cw.opcode = i_opcode;
        o_cw.aluop = alu_add;

        case (i_opcode)
            op_add: begin
                o_cw.alumux_sel = i_ir_5 ? alumux_imm5 : alumux_reg;
                o_cw.load_regfile = 1'b1;
                o_cw.load_cc = 1'b1;
            end
            op_and: begin
                o_cw.aluop = alu_and;
                o_cw.alumux_sel = i_ir_5 ? alumux_imm5 : alumux_reg;
                o_cw.load_regfile = 1'b1;
                o_cw.load_cc = 1'b1;
            end
            op_not: begin
                o_cw.aluop = alu_not;
                o_cw.load_regfile = 1'b1;
                o_cw.load_cc = 1'b1;
            end
            op_ldr: begin
                o_cw.alumux_sel = alumux_off6;
                o_cw.offset6_lsse = 1'b1;
                o_cw.d_mem_read = 1'b1;
                o_cw.load_regfile = 1'b1;
                o_cw.load_cc = 1'b1;
                o_cw.regfilemux_sel = 1'b1;
            end
            op_str: begin
                o_cw.alumux_sel = alumux_off6;
                o_cw.offset6_lsse = 1'b1;
                o_cw.d_mem_write = 1'b1;
                o_cw.src2_is_dest = 1'b1;
            end
            // byte offset, no shift
            op_stb: begin
                o_cw.alumux_sel = alumux_off6;
                o_cw.d_mem_write = 1'b1;
                o_cw.src2_is_dest = 1'b1;
            end
            // BR is resolved in writeback, nothing to enable here
            default: begin
                o_cw.aluop = alu_pass;
            end
        endcase
    end

endmodule

//--- source/hazard_detection.sv
module hazard_detection import lc3b_pkg::*; (
    input  logic    i_arst_n,
    input  logic    clk,
    input  logic    i_i_mem_resp,
    input  logic    i_d_mem_resp,
    input  logic    i_d_access_mem,
    input  logic    i_load_ex,
    input  lc3b_reg i_dest_ex,
    input  lc3b_reg i_src1_id,
    input  lc3b_reg i_src2_id,
    input  logic    i_src2_used_id,
    input  logic    i_br_taken,
    output logic    o_load,
    output logic    o_bubble_ex,
    output logic    o_flush,
    output logic    o_i_mem_read
);

    typedef enum logic [1:0] {RESET_WAIT, RUN, LOAD_USE, REDIRECT} state_t;

    state_t state;
    state_t state_next;
    // fetch response taken but not yet consumed by decode
    logic   i_held;
    logic   advance;
    logic   load_use;

    assign advance = (i_i_mem_resp || i_held) && (!i_d_access_mem || i_d_mem_resp);
    assign load_use = i_load_ex &&
                      ((i_src1_id == i_dest_ex) || (i_src2_used_id && (i_src2_id == i_dest_ex)));

    always_comb begin
        state_next = state;
        o_load = 1'b0;
        o_bubble_ex = 1'b0;
        o_flush = 1'b0;
        o_i_mem_read = 1'b0;

        case (state)
            RESET_WAIT: state_next = RUN;
            RUN, LOAD_USE: begin
                o_i_mem_read = !i_held;
                if (i_br_taken) begin
                    if (advance) begin
                        o_load = 1'b1;
                        o_flush = 1'b1;
                        state_next = REDIRECT;
                    end
                end else if (state == LOAD_USE) begin
                    // front end holds while the load moves on alone
                    if (advance) begin
                        o_load = 1'b1;
                        o_bubble_ex = 1'b1;
                        state_next = RUN;
                    end
                end else if (load_use) begin
                    state_next = LOAD_USE;
                end else begin
                    o_load = advance;
                end
            end
            // read level low for a cycle while the new PC settles
            REDIRECT: state_next = RUN;
            default: state_next = RESET_WAIT;
        endcase
    end

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state <= RESET_WAIT;
            i_held <= 1'b0;
        end else begin
            state <= state_next;
            if (state != RUN && state != LOAD_USE) begin
                i_held <= 1'b0;
            end else if (o_load && !o_bubble_ex) begin
                i_held <= 1'b0;
            end else if (i_i_mem_resp) begin
                i_held <= 1'b1;
            end
        end
    end

    // read level stays up until the memory answers
    a_i_read_held: assert property (
        @(posedge clk) disable iff (!i_arst_n)
        (o_i_mem_read && !i_i_mem_resp) |=> o_i_mem_read
    );

endmodule

//--- source/lc3b_cpu.sv
module lc3b_cpu import lc3b_pkg::*; #(
    parameter lc3b_word RESET_PC = 16'h0000
) (
    input  logic       i_arst_n,
    input  logic       clk,

    input  logic       i_i_mem_resp,
    input  lc3b_word   i_i_mem_rdata,
    output lc3b_word   o_i_mem_address,
    output logic       o_i_mem_read,

    input  logic       i_d_mem_resp,
    input  lc3b_word   i_d_mem_rdata,
    output lc3b_word   o_d_mem_address,
    output lc3b_word   o_d_mem_wdata,
    output logic       o_d_mem_read,
    output logic       o_d_mem_write,
    output logic [1:0] o_d_mem_byte_enable
);

    lc3b_control_word cw;
    lc3b_opcode       opcode;
    logic             ir_5;
    logic             load;
    logic             bubble_ex;
    logic             flush;
    lc3b_reg          src1_id;
    lc3b_reg          src2_id;
    logic             src2_used_id;
    logic             load_ex;
    lc3b_reg          dest_ex;
    logic             br_taken;
    logic             d_access_mem;

    control_rom control_rom_i (
        .i_opcode (opcode),
        .i_ir_5   (ir_5),
        .o_cw     (cw)
    );

    hazard_detection hazard_detection_i (
        .i_arst_n       (i_arst_n),
        .clk            (clk),
        .i_i_mem_resp   (i_i_mem_resp),
        .i_d_mem_resp   (i_d_mem_resp),
        .i_d_access_mem (d_access_mem),
        .i_load_ex      (load_ex),
        .i_dest_ex      (dest_ex),
        .i_src1_id      (src1_id),
        .i_src2_id      (src2_id),
        .i_src2_used_id (src2_used_id),
        .i_br_taken     (br_taken),
        .o_load         (load),
        .o_bubble_ex    (bubble_ex),
        .o_flush        (flush),
        .o_i_mem_read   (o_i_mem_read)
    );

    cpu_datapath #(
        .RESET_PC (RESET_PC)
    ) cpu_datapath_i (
        .i_arst_n            (i_arst_n),
        .clk                 (clk),
        .i_cw                (cw),
        .i_load              (load),
        .i_bubble_ex         (bubble_ex),
        .i_flush             (flush),
        .i_i_mem_resp        (i_i_mem_resp),
        .i_i_mem_rdata       (i_i_mem_rdata),
        .o_i_mem_address     (o_i_mem_address),
        .o_opcode            (opcode),
        .o_ir_5              (ir_5),
        .o_src1_id           (src1_id),
        .o_src2_id           (src2_id),
        .o_src2_used_id      (src2_used_id),
        .o_load_ex           (load_ex),
        .o_dest_ex           (dest_ex),
        .o_br_taken          (br_taken),
        .o_d_access_mem      (d_access_mem),
        .i_d_mem_resp        (i_d_mem_resp),
        .i_d_mem_rdata       (i_d_mem_rdata),
        .o_d_mem_address     (o_d_mem_address),
        .o_d_mem_wdata       (o_d_mem_wdata),
        .o_d_mem_read        (o_d_mem_read),
        .o_d_mem_write       (o_d_mem_write),
        .o_d_mem_byte_enable (o_d_mem_byte_enable)
    );

endmodule
